// File: flist.f
+incdir+src
src/subway_pkg.sv
src/map_loader.sv
src/route_planner.sv
src/move_streamer.sv
src/subway_top.sv
sim/tb_clk_gen.sv
sim/subway_chk.sv
sim/subway_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= subway_tb
FLIST     ?= flist.f
LOG       ?= sim.log
SEED      ?= 10831
OBJ_DIR   ?= obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f $(FLIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) +verilator+rand+reset+2 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "no pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/subway_tb.sv
`timescale 1ns/1ps
`include "subway_macros.svh"

module subway_tb;

    localparam int NUM_ROWS        = 9;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 150 + 50;

    typedef struct packed {
        logic [1:0]      start;
        logic [0:6][2:0] ckpt;
        logic [3:0]      density;
        logic [2:0]      final_lane;
    } row_t;

    // checkpoint code 0..3 gives the road lane, 4 blocks every lane, 5 leaves the column random
    // final lane 7 takes the model's final lane
    row_t rows [NUM_ROWS] = '{
        '{2'd2, {3'd2, 3'd2, 3'd2, 3'd2, 3'd2, 3'd2, 3'd2}, 4'd0, 3'd2},
        '{2'd0, {3'd1, 3'd3, 3'd0, 3'd3, 3'd1, 3'd2, 3'd0}, 4'd0, 3'd0},
        '{2'd3, {3'd2, 3'd0, 3'd3, 3'd2, 3'd1, 3'd0, 3'd1}, 4'd0, 3'd1},
        '{2'd1, {3'd1, 3'd1, 3'd1, 3'd1, 3'd1, 3'd1, 3'd1}, 4'd6, 3'd1},
        '{2'd0, {3'd2, 3'd0, 3'd3, 3'd1, 3'd0, 3'd2, 3'd3}, 4'd8, 3'd3},
        '{2'd0, {3'd4, 3'd1, 3'd4, 3'd4, 3'd0, 3'd4, 3'd2}, 4'd2, 3'd2},
        '{2'd1, {3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5}, 4'd5, 3'd7},
        '{2'd3, {3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5}, 4'd5, 3'd7},
        '{2'd0, {3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5}, 4'd5, 3'd7}
    };
    string names [NUM_ROWS] = '{"straight_lane2", "shift_mixed_a", "shift_mixed_b",
        "jumps_hold", "jumps_weave", "no_road", "random_a", "random_b", "random_c"};

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    subway_pkg::lane_t init;
    subway_pkg::cell_t in0;
    subway_pkg::cell_t in1;
    subway_pkg::cell_t in2;
    subway_pkg::cell_t in3;
    logic              out_valid;
    subway_pkg::move_t out;

    logic [1:0] cells [`SUBWAY_COLS][`SUBWAY_LANES];
    logic [1:0] exp_mv [`SUBWAY_NUM_MOVES];
    int         exp_final;
    integer     seed = 32'h2a4f;
    int         mismatch_cnt = 0;
    int         proto_cnt = 0;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    subway_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .init      (init),
        .in0       (in0),
        .in1       (in1),
        .in2       (in2),
        .in3       (in3),
        .out_valid (out_valid),
        .out       (out)
    );

    bind subway_top subway_chk u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .out       (out)
    );

    // ##########################################################################
    // map building and reference model
    // ##########################################################################
    task automatic build_map(input row_t r);
        logic [31:0] rnd;
        int          code;
        for (int c = 0; c < `SUBWAY_COLS; c++) begin
            for (int l = 0; l < `SUBWAY_LANES; l++) begin
                rnd = $random(seed);
                if (c != 0 && c % `SUBWAY_SEG_LEN == 0) begin
                    code = int'(r.ckpt[c / `SUBWAY_SEG_LEN - 1]);
                    if (code == 5)
                        cells[c][l] = rnd[1:0];
                    else if (code == 4 || l < code)
                        cells[c][l] = 2'(rnd[7:0] % 8'd3) + 2'd1;
                    else if (l == code)
                        cells[c][l] = 2'd0;
                    else
                        cells[c][l] = rnd[1:0];
                end else if (rnd[3:0] < r.density) begin
                    cells[c][l] = 2'd1;
                end else begin
                    cells[c][l] = (rnd[5:4] == 2'd3) ? 2'd2 : 2'd0;
                end
            end
        end
    endtask

    task automatic compute_expected(input logic [1:0] start);
        int tgt [`SUBWAY_NUM_CKPT];
        int lane;
        int seg;
        int off;
        bit change;
        for (int k = 0; k < `SUBWAY_NUM_CKPT; k++) begin
            tgt[k] = 3;
            for (int l = 3; l >= 0; l--) begin
                if (cells[(k + 1) * `SUBWAY_SEG_LEN][l] == 2'd0)
                    tgt[k] = l;
            end
        end
        lane = int'(start);
        for (int m = 0; m < `SUBWAY_NUM_MOVES; m++) begin
            seg = m / `SUBWAY_SEG_LEN;
            off = m % `SUBWAY_SEG_LEN;
            exp_mv[m] = 2'd0;
            change = (off == 4 || off == 6 || off == 7) && seg < `SUBWAY_NUM_CKPT;
            if (change)
                change = (lane != tgt[seg]);
            if (change) begin
                exp_mv[m] = (tgt[seg] > lane) ? 2'd1 : 2'd2;
                lane = (tgt[seg] > lane) ? lane + 1 : lane - 1;
            end else if ((off == 1 || off == 3 || off == 5) && cells[m + 1][lane] == 2'd1) begin
                exp_mv[m] = 2'd3;
            end
        end
        exp_final = lane;
    endtask

    // ##########################################################################
    // frame drive and burst collection
    // ##########################################################################
    task automatic drive_frame(input logic [1:0] start);
        for (int c = 0; c < `SUBWAY_COLS; c++) begin
            @(negedge clk);
            in_valid = 1'b1;
            init     = start;
            in0      = subway_pkg::cell_t'(cells[c][0]);
            in1      = subway_pkg::cell_t'(cells[c][1]);
            in2      = subway_pkg::cell_t'(cells[c][2]);
            in3      = subway_pkg::cell_t'(cells[c][3]);
        end
        @(negedge clk);
        in_valid = 1'b0;
        in0      = subway_pkg::CELL_ROAD;
        in1      = subway_pkg::CELL_ROAD;
        in2      = subway_pkg::CELL_ROAD;
        in3      = subway_pkg::CELL_ROAD;
    endtask

    task automatic collect_burst(input string name, input logic [1:0] start,
                                 input int exp_lane);
        int waited;
        int n;
        int lane_now;
        waited = 0;
        n = 0;
        lane_now = int'(start);
        while (!out_valid && waited < 20) begin
            assert (out == subway_pkg::MV_FWD) else begin
                $display("MISMATCH %s idle out: expected %0d, actual %0d", name, 0, out);
                mismatch_cnt++;
            end
            @(negedge clk);
            waited++;
        end
        assert (out_valid) else begin
            $display("%s: no output burst arrived after the frame was loaded", name);
            proto_cnt++;
        end
        if (out_valid) begin
            while (out_valid && n < 70) begin
                if (n < `SUBWAY_NUM_MOVES) begin
                    assert (out == exp_mv[n]) else begin
                        $display("MISMATCH %s move %0d: expected %0d, actual %0d",
                                 name, n, exp_mv[n], out);
                        mismatch_cnt++;
                    end
                end
                // runner lane as the DUT moves it
                if (out == subway_pkg::MV_RIGHT)
                    lane_now++;
                else if (out == subway_pkg::MV_LEFT)
                    lane_now--;
                n++;
                @(negedge clk);
            end
            assert (n == `SUBWAY_NUM_MOVES) else begin
                $display("%s: output burst lasted %0d cycles instead of 63", name, n);
                proto_cnt++;
            end
            assert (lane_now == exp_lane) else begin
                $display("MISMATCH %s final lane: expected %0d, actual %0d",
                         name, exp_lane, lane_now);
                mismatch_cnt++;
            end
        end
    endtask

    initial begin
        in_valid = 1'b0;
        init     = '0;
        in0      = subway_pkg::CELL_ROAD;
        in1      = subway_pkg::CELL_ROAD;
        in2      = subway_pkg::CELL_ROAD;
        in3      = subway_pkg::CELL_ROAD;
        @(posedge rst_n);
        for (int r = 0; r < NUM_ROWS; r++) begin
            build_map(rows[r]);
            compute_expected(rows[r].start);
            drive_frame(rows[r].start);
            collect_burst(names[r], rows[r].start,
                          (rows[r].final_lane == 3'd7) ? exp_final
                                                       : int'(rows[r].final_lane));
        end
        @(negedge clk);
        $display("errors: %0d mismatch, %0d protocol, %0d assertion",
                 mismatch_cnt, proto_cnt, u_dut.u_chk.fail_cnt);
        if (mismatch_cnt + proto_cnt + u_dut.u_chk.fail_cnt == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: %0d mismatch, %0d protocol, %0d assertion",
                 mismatch_cnt, proto_cnt, u_dut.u_chk.fail_cnt);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: sim/subway_chk.sv
`timescale 1ns/1ps

module subway_chk (
    input logic       clk,
    input logic       rst_n,
    input logic       in_valid,
    input logic       out_valid,
    input logic [1:0] out
);

    int         fail_cnt = 0;
    logic [6:0] burst_len;

    // cycles of out_valid so far in the current burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            burst_len <= '0;
        else if (out_valid)
            burst_len <= burst_len + 7'd1;
        else
            burst_len <= '0;
    end

    a_out_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out == 2'd0)
        else begin
            fail_cnt++;
            $error("out is not zero while out_valid is low");
        end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_valid && in_valid))
        else begin
            fail_cnt++;
            $error("out_valid and in_valid are high in the same cycle");
        end

    // burst ends after exactly 63 moves and never runs longer
    a_burst_end: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(out_valid) |-> burst_len == 7'd63)
        else begin
            fail_cnt++;
            $error("output burst ended after %0d cycles", $sampled(burst_len));
        end

    a_burst_max: assert property (@(posedge clk) disable iff (!rst_n)
        burst_len <= 7'd63)
        else begin
            fail_cnt++;
            $error("output burst runs past 63 cycles");
        end

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release reset away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: src/subway_top.sv
`timescale 1ns/1ps

module subway_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  subway_pkg::lane_t init,
    input  subway_pkg::cell_t in0,
    input  subway_pkg::cell_t in1,
    input  subway_pkg::cell_t in2,
    input  subway_pkg::cell_t in3,
    output logic              out_valid,
    output subway_pkg::move_t out
);

    subway_pkg::map_t   map;
    subway_pkg::lane_t  start_lane;
    subway_pkg::route_t route;
    logic               map_done;
    logic               route_done;

    map_loader u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .init       (init),
        .in0        (in0),
        .in1        (in1),
        .in2        (in2),
        .in3        (in3),
        .map        (map),
        .start_lane (start_lane),
        .map_done   (map_done)
    );

    route_planner u_planner (
        .clk        (clk),
        .rst_n      (rst_n),
        .map        (map),
        .start_lane (start_lane),
        .map_done   (map_done),
        .route      (route),
        .route_done (route_done)
    );

    // streamer reads the map too, for jumps
    move_streamer u_streamer (
        .clk        (clk),
        .rst_n      (rst_n),
        .map        (map),
        .route      (route),
        .route_done (route_done),
        .out_valid  (out_valid),
        .out        (out)
    );

endmodule

// File: src/move_streamer.sv
`timescale 1ns/1ps
`include "subway_macros.svh"

module move_streamer (
    input  logic               clk,
    input  logic               rst_n,
    input  subway_pkg::map_t   map,
    input  subway_pkg::route_t route,
    input  logic               route_done,
    output logic               out_valid,
    output subway_pkg::move_t  out
);

    subway_pkg::stream_state_t state;
    subway_pkg::step_t         step;
    subway_pkg::step_t         nxt_col;
    subway_pkg::lane_t         lane;
    subway_pkg::lane_t         lane_nxt;
    subway_pkg::lane_t         tgt;
    subway_pkg::move_t         mv;
    logic [2:0]                off;
    logic [2:0]                seg;
    logic [2:0]                seg_idx;
    logic                      seg_ok;
    logic                      chg_slot;
    logic                      jmp_slot;

    // ##########################################################################
    // move decision for step m, column m to m+1
    // ##########################################################################
    assign off     = step[2:0];
    assign seg     = step[5:3];
    assign seg_ok  = seg < 3'(`SUBWAY_NUM_CKPT);
    assign seg_idx = seg_ok ? seg : 3'd0;
    assign tgt     = route.target[seg_idx];
    assign nxt_col = step + subway_pkg::step_t'(1);

    assign chg_slot = (off == 3'd4) || (off == 3'd6) || (off == 3'd7);
    assign jmp_slot = (off == 3'd1) || (off == 3'd3) || (off == 3'd5);

    always_comb begin
        mv       = subway_pkg::MV_FWD;
        lane_nxt = lane;
        if (chg_slot && seg_ok && (lane != tgt)) begin
            // one lane per slot toward the segment target
            if (tgt > lane) begin
                mv       = subway_pkg::MV_RIGHT;
                lane_nxt = lane + subway_pkg::lane_t'(1);
            end else begin
                mv       = subway_pkg::MV_LEFT;
                lane_nxt = lane - subway_pkg::lane_t'(1);
            end
        end else if (jmp_slot && (map[nxt_col][lane] == subway_pkg::CELL_LOW)) begin
            mv = subway_pkg::MV_JUMP;
        end
    end

    // ##########################################################################
    // burst control
    // ##########################################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= subway_pkg::ST_IDLE;
            step  <= '0;
            lane  <= '0;
        end else begin
            case (state)
                subway_pkg::ST_IDLE: begin
                    if (route_done) begin
                        state <= subway_pkg::ST_OUT;
                        step  <= '0;
                        lane  <= route.start;
                    end
                end
                subway_pkg::ST_OUT: begin
                    lane <= lane_nxt;
                    step <= step + subway_pkg::step_t'(1);
                    if (step == subway_pkg::step_t'(`SUBWAY_NUM_MOVES - 1))
                        state <= subway_pkg::ST_IDLE;
                end
            endcase
        end
    end

    assign out_valid = (state == subway_pkg::ST_OUT);
    assign out       = out_valid ? mv : subway_pkg::MV_FWD;

endmodule

// File: src/route_planner.sv
`timescale 1ns/1ps
`include "subway_macros.svh"

module route_planner (
    input  logic               clk,
    input  logic               rst_n,
    input  subway_pkg::map_t   map,
    input  subway_pkg::lane_t  start_lane,
    input  logic               map_done,
    output subway_pkg::route_t route,
    output logic               route_done
);

    subway_pkg::plan_state_t state;
    logic [2:0]              ck_cnt;
    logic [2:0]              ck_idx;
    logic                    ck_first;
    logic                    ck_active;
    subway_pkg::step_t       ck_col;
    subway_pkg::lane_t       free_lane;

    // checkpoint 0 is handled in the map_done cycle itself
    assign ck_first  = (state == subway_pkg::PL_IDLE) && map_done;
    assign ck_active = ck_first || (state == subway_pkg::PL_RUN);
    assign ck_idx    = (state == subway_pkg::PL_RUN) ? ck_cnt : 3'd0;
    assign ck_col    = subway_pkg::step_t'((ck_idx + 1) * `SUBWAY_SEG_LEN);

    // lowest road lane wins, lane 3 when the column is fully blocked
    always_comb begin
        free_lane = subway_pkg::lane_t'(`SUBWAY_LANES - 1);
        for (int l = `SUBWAY_LANES - 1; l >= 0; l--) begin
            if (map[ck_col][l] == subway_pkg::CELL_ROAD)
                free_lane = subway_pkg::lane_t'(l);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= subway_pkg::PL_IDLE;
            ck_cnt     <= '0;
            route_done <= 1'b0;
        end else begin
            route_done <= 1'b0;
            case (state)
                subway_pkg::PL_IDLE: begin
                    if (map_done) begin
                        state  <= subway_pkg::PL_RUN;
                        ck_cnt <= 3'd1;
                    end
                end
                subway_pkg::PL_RUN: begin
                    if (ck_cnt == 3'(`SUBWAY_NUM_CKPT - 1)) begin
                        state      <= subway_pkg::PL_IDLE;
                        route_done <= 1'b1;
                    end else begin
                        ck_cnt <= ck_cnt + 3'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ck_first)
            route.start <= start_lane;
        if (ck_active)
            route.target[ck_idx] <= free_lane;
    end

endmodule

// File: src/map_loader.sv
`timescale 1ns/1ps
`include "subway_macros.svh"

module map_loader (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  subway_pkg::lane_t init,
    input  subway_pkg::cell_t in0,
    input  subway_pkg::cell_t in1,
    input  subway_pkg::cell_t in2,
    input  subway_pkg::cell_t in3,
    output subway_pkg::map_t  map,
    output subway_pkg::lane_t start_lane,
    output logic              map_done
);

    subway_pkg::step_t   col_cnt;
    subway_pkg::column_t col_in;
    logic                last_col;

    always_comb begin
        col_in[0] = in0;
        col_in[1] = in1;
        col_in[2] = in2;
        col_in[3] = in3;
    end

    // last_col marks that column 63 went in, map_done once in_valid drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt  <= '0;
            last_col <= 1'b0;
            map_done <= 1'b0;
        end else begin
            col_cnt  <= in_valid ? col_cnt + subway_pkg::step_t'(1) : '0;
            last_col <= in_valid && (col_cnt == subway_pkg::step_t'(`SUBWAY_COLS - 1));
            map_done <= last_col && !in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            map[col_cnt] <= col_in;
            // start lane comes with the first column only
            if (col_cnt == '0)
                start_lane <= init;
        end
    end

endmodule

// File: src/subway_pkg.sv
`include "subway_macros.svh"

package subway_pkg;

    typedef enum logic [1:0] {
        CELL_ROAD  = 2'd0,
        CELL_LOW   = 2'd1,
        CELL_HIGH  = 2'd2,
        CELL_TRAIN = 2'd3
    } cell_t;

    typedef enum logic [1:0] {
        MV_FWD   = 2'd0,
        MV_RIGHT = 2'd1,
        MV_LEFT  = 2'd2,
        MV_JUMP  = 2'd3
    } move_t;

    typedef logic [1:0] lane_t;
    typedef logic [5:0] step_t;

    // one column, indexed by lane
    typedef cell_t [`SUBWAY_LANES-1:0] column_t;
    typedef column_t [`SUBWAY_COLS-1:0] map_t;

    typedef struct packed {
        lane_t                             start;
        lane_t [`SUBWAY_NUM_CKPT-1:0] target;
    } route_t;

    typedef enum logic {PL_IDLE, PL_RUN} plan_state_t;
    typedef enum logic {ST_IDLE, ST_OUT} stream_state_t;

endpackage

// File: src/subway_macros.svh
`ifndef SUBWAY_MACROS_SVH
`define SUBWAY_MACROS_SVH

// ##########################################################################
// track geometry
// ##########################################################################

// lanes across the track
`define SUBWAY_LANES 4

// columns per frame
`define SUBWAY_COLS 64

// columns between checkpoints
`define SUBWAY_SEG_LEN 8

// moves per burst, one per column step
`define SUBWAY_NUM_MOVES 63
`define SUBWAY_NUM_CKPT 7

`endif
